// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= crtc_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_TEXT)$$"

clean:
	rm -rf $(BUILD_DIR)

// ==== src/crtc_pkg.sv ====
package crtc_pkg;

    typedef logic [7:0]  char_cnt_t;        // Characters along a line or rows in a frame
    typedef logic [4:0]  line_cnt_t;        // Scanline inside a row, also adjust lines
    typedef logic [3:0]  sync_width_t;      // Sync width, 0 stands for 16
    typedef logic [10:0] mem_addr_t;        // Video RAM address
    typedef logic [11:0] bus_addr_t;        // Shared RAM and ROM bus address
    typedef logic [7:0]  byte_t;            // Register or bus data
    typedef logic [2:0]  pixel_phase_t;     // Pixel position inside a character

    // CRTC register indices
    localparam logic [3:0] R0_H_TOTAL           = 4'd0;
    localparam logic [3:0] R1_H_DISPLAYED       = 4'd1;
    localparam logic [3:0] R2_H_SYNC_POS        = 4'd2;
    localparam logic [3:0] R3_SYNC_WIDTH        = 4'd3;     // [3:0] h width, [7:4] v width
    localparam logic [3:0] R4_V_TOTAL           = 4'd4;
    localparam logic [3:0] R5_V_LINE_ADJUST     = 4'd5;
    localparam logic [3:0] R6_V_DISPLAYED       = 4'd6;
    localparam logic [3:0] R7_V_SYNC_POS        = 4'd7;
    localparam logic [3:0] R9_SCAN_LINE         = 4'd9;
    localparam logic [3:0] R12_DISPLAY_START_HI = 4'd12;
    localparam logic [3:0] R13_DISPLAY_START_LO = 4'd13;

    localparam int PIXELS_PER_CHAR = 8;

    // Fetch schedule inside one character period
    localparam pixel_phase_t PHASE_RAM_ADDR = 3'd0;     // RAM address for phases 0 and 1
    localparam pixel_phase_t PHASE_ROM_ADDR = 3'd2;     // ROM address for phases 2 and 3
    localparam pixel_phase_t PHASE_LOAD     = 3'd7;     // Shift register load

    typedef enum logic [2:0] {
        ACTIVE,         // Visible part of the line or frame
        FRONT,          // Blank before sync
        SYNC,           // Sync pulse
        BACK,           // Blank after sync
        ADJUST          // Extra scanlines at frame end
    } sync_state_t;

endpackage

// ==== src/crtc_regs.sv ====
`timescale 1ns/1ps

module crtc_regs (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    input  logic                    we_i,
    input  logic [3:0]              addr_i,
    input  crtc_pkg::byte_t         wdata_i,
    output crtc_pkg::char_cnt_t     h_total_o,
    output crtc_pkg::char_cnt_t     h_displayed_o,
    output crtc_pkg::char_cnt_t     h_sync_pos_o,
    output crtc_pkg::sync_width_t   h_sync_width_o,
    output crtc_pkg::sync_width_t   v_sync_width_o,
    output crtc_pkg::char_cnt_t     v_total_o,
    output crtc_pkg::char_cnt_t     v_displayed_o,
    output crtc_pkg::char_cnt_t     v_sync_pos_o,
    output crtc_pkg::line_cnt_t     char_height_o,
    output crtc_pkg::line_cnt_t     v_adjust_o,
    output crtc_pkg::mem_addr_t     display_start_o
);
    import crtc_pkg::*;

    byte_t regs [16];

    // NTSC-like default mode, 40x25 characters
    function automatic byte_t reset_value(logic [3:0] idx);
        case (idx)
            R0_H_TOTAL:       return 8'd63;
            R1_H_DISPLAYED:   return 8'd40;
            R2_H_SYNC_POS:    return 8'd48;
            R3_SYNC_WIDTH:    return 8'h15;
            R4_V_TOTAL:       return 8'd32;
            R6_V_DISPLAYED:   return 8'd25;
            R7_V_SYNC_POS:    return 8'd28;
            R9_SCAN_LINE:     return 8'd7;
            default:          return 8'h00;   // R5, R12, R13 and the unused slots
        endcase
    endfunction

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            for (int i = 0; i < 16; i++) begin
                regs[i] <= reset_value(4'(i));
            end
        end else if (we_i) begin
            regs[addr_i] <= wdata_i;
        end
    end

    assign h_total_o       = regs[R0_H_TOTAL];
    assign h_displayed_o   = regs[R1_H_DISPLAYED];
    assign h_sync_pos_o    = regs[R2_H_SYNC_POS];
    assign h_sync_width_o  = regs[R3_SYNC_WIDTH][3:0];
    assign v_sync_width_o  = regs[R3_SYNC_WIDTH][7:4];
    assign v_total_o       = {1'b0, regs[R4_V_TOTAL][6:0]};       // Vertical values are 7 bit
    assign v_displayed_o   = {1'b0, regs[R6_V_DISPLAYED][6:0]};
    assign v_sync_pos_o    = {1'b0, regs[R7_V_SYNC_POS][6:0]};
    assign char_height_o   = regs[R9_SCAN_LINE][4:0];
    assign v_adjust_o      = regs[R5_V_LINE_ADJUST][4:0];
    assign display_start_o = {regs[R12_DISPLAY_START_HI][2:0], regs[R13_DISPLAY_START_LO]};

endmodule

// ==== src/crtc_video_top.sv ====
`timescale 1ns/1ps

module crtc_video_top (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    input  logic                    reg_we_i,
    input  logic [3:0]              reg_addr_i,
    input  crtc_pkg::byte_t         reg_wdata_i,
    output crtc_pkg::bus_addr_t     bus_addr_o,         // RAM at 000-7FF, ROM at 800-FFF
    input  crtc_pkg::byte_t         bus_data_i,
    output logic                    video_o,
    output logic                    h_sync_o,
    output logic                    v_sync_o
);
    import crtc_pkg::*;

    char_cnt_t   h_total;
    char_cnt_t   h_displayed;
    char_cnt_t   h_sync_pos;
    sync_width_t h_sync_width;
    sync_width_t v_sync_width;
    char_cnt_t   v_total;
    char_cnt_t   v_displayed;
    char_cnt_t   v_sync_pos;
    line_cnt_t   char_height;
    line_cnt_t   v_adjust;
    mem_addr_t   display_start;

    timing_if h_bus ();
    timing_if v_bus ();

    crtc_regs regs (
        .pixel_clk_i     (pixel_clk_i),
        .reset_i         (reset_i),
        .we_i            (reg_we_i),
        .addr_i          (reg_addr_i),
        .wdata_i         (reg_wdata_i),
        .h_total_o       (h_total),
        .h_displayed_o   (h_displayed),
        .h_sync_pos_o    (h_sync_pos),
        .h_sync_width_o  (h_sync_width),
        .v_sync_width_o  (v_sync_width),
        .v_total_o       (v_total),
        .v_displayed_o   (v_displayed),
        .v_sync_pos_o    (v_sync_pos),
        .char_height_o   (char_height),
        .v_adjust_o      (v_adjust),
        .display_start_o (display_start)
    );

    h_timing h_gen (
        .pixel_clk_i      (pixel_clk_i),
        .reset_i          (reset_i),
        .char_total_i     (h_total),
        .char_displayed_i (h_displayed),
        .sync_start_i     (h_sync_pos),
        .sync_width_i     (h_sync_width),
        .tim_o            (h_bus)
    );

    v_timing v_gen (
        .pixel_clk_i      (pixel_clk_i),
        .reset_i          (reset_i),
        .line_end_i       (h_bus),
        .char_height_i    (char_height),
        .adjust_i         (v_adjust),
        .char_total_i     (v_total),
        .char_displayed_i (v_displayed),
        .sync_start_i     (v_sync_pos),
        .sync_width_i     (v_sync_width),
        .tim_o            (v_bus)
    );

    dot_gen dots (
        .pixel_clk_i     (pixel_clk_i),
        .reset_i         (reset_i),
        .h_i             (h_bus),
        .v_i             (v_bus),
        .h_displayed_i   (h_displayed),
        .display_start_i (display_start),
        .bus_addr_o      (bus_addr_o),
        .bus_data_i      (bus_data_i),
        .video_o         (video_o)
    );

    assign h_sync_o = h_bus.sync;   // Straight from the state registers
    assign v_sync_o = v_bus.sync;

endmodule

// ==== src/dot_gen.sv ====
`timescale 1ns/1ps

module dot_gen (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    timing_if.sink                  h_i,
    timing_if.sink                  v_i,
    input  crtc_pkg::char_cnt_t     h_displayed_i,      // Row stride in RAM
    input  crtc_pkg::mem_addr_t     display_start_i,
    output crtc_pkg::bus_addr_t     bus_addr_o,
    input  crtc_pkg::byte_t         bus_data_i,         // Data for last cycle's address
    output logic                    video_o
);
    import crtc_pkg::*;

    pixel_phase_t phase;
    line_cnt_t    scan;
    logic         new_frame;        // First cycle of a frame
    char_cnt_t    last_row;
    mem_addr_t    row_base;         // RAM address of the first character in this row
    mem_addr_t    cur_base;
    mem_addr_t    ram_addr;
    logic         rom_window;
    byte_t        code;
    byte_t        glyph;
    byte_t        pixels;
    logic         reverse;
    logic         gate;             // Active level of the character being shifted

    assign phase = h_i.sub_count[2:0];
    assign scan  = v_i.sub_count;

    // Row base follows the row counter, first cycle of a new row sees the updated value
    always_comb begin
        if (new_frame) begin
            cur_base = display_start_i;
        end else if (v_i.count != last_row) begin
            cur_base = row_base + mem_addr_t'(h_displayed_i);
        end else begin
            cur_base = row_base;
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            new_frame <= 1'b0;
            last_row  <= '0;
            row_base  <= '0;
        end else begin
            new_frame <= h_i.wrap && v_i.wrap;
            last_row  <= v_i.count;
            row_base  <= cur_base;
        end
    end

    assign ram_addr   = cur_base + mem_addr_t'(h_i.count);
    assign rom_window = (phase == PHASE_ROM_ADDR) || (phase == PHASE_ROM_ADDR + 3'd1);

    always_comb begin
        if (rom_window) begin
            bus_addr_o = {2'b10, code[6:0], scan[2:0]};     // Character ROM
        end else begin
            bus_addr_o = {1'b0, ram_addr};                  // Video RAM
        end
    end

    // Each address is held two cycles, data taken at the end of the second
    always_ff @(posedge pixel_clk_i) begin
        if (phase == PHASE_RAM_ADDR + 3'd1) begin
            code <= bus_data_i;
        end
        if (phase == PHASE_ROM_ADDR + 3'd1) begin
            glyph <= bus_data_i;
        end
    end

    always_ff @(posedge pixel_clk_i) begin
        if (phase == PHASE_LOAD) begin
            pixels  <= glyph;
            reverse <= code[7];
        end else begin
            pixels <= {pixels[6:0], 1'b0};   // MSB first
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            gate <= 1'b0;
        end else if (phase == PHASE_LOAD) begin
            gate <= h_i.active && v_i.active;
        end
    end

    assign video_o = (pixels[7] ^ reverse) & gate;

endmodule

// ==== src/h_timing.sv ====
`timescale 1ns/1ps

module h_timing (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    input  crtc_pkg::char_cnt_t     char_total_i,       // Characters per line minus one
    input  crtc_pkg::char_cnt_t     char_displayed_i,   // Displayed characters per line
    input  crtc_pkg::char_cnt_t     sync_start_i,       // First character of hsync
    input  crtc_pkg::sync_width_t   sync_width_i,       // Hsync width in characters
    timing_if.gen                   tim_o
);
    import crtc_pkg::*;

    pixel_phase_t phase;
    logic         char_end;         // Character strobe, last pixel of a character
    char_cnt_t    char_count;
    char_cnt_t    next_char;
    char_cnt_t    sync_end;
    sync_state_t  state;
    sync_state_t  next_state;

    assign char_end  = phase == pixel_phase_t'(PIXELS_PER_CHAR - 1);
    assign next_char = char_count + 1'b1;
    assign sync_end  = sync_start_i + char_cnt_t'({sync_width_i == '0, sync_width_i});

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            phase <= '0;
        end else begin
            phase <= char_end ? '0 : phase + 1'b1;
        end
    end

    // Same priority as the reference sync generator
    always_comb begin
        if (next_char == sync_end) begin
            next_state = BACK;
        end else if (next_char == sync_start_i) begin
            next_state = SYNC;
        end else if (next_char == char_displayed_i) begin
            next_state = FRONT;
        end else begin
            next_state = state;
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            char_count <= '0;
            state      <= ACTIVE;
        end else if (char_end) begin
            if (char_count == char_total_i) begin
                char_count <= '0;           // Line wraps after character R0
                state      <= ACTIVE;
            end else begin
                char_count <= next_char;
                state      <= next_state;
            end
        end
    end

    assign tim_o.active    = state == ACTIVE;
    assign tim_o.sync      = state == SYNC;
    assign tim_o.count     = char_count;
    assign tim_o.sub_count = line_cnt_t'(phase);
    assign tim_o.wrap      = char_end && (char_count == char_total_i);

endmodule

// ==== src/timing_if.sv ====
`timescale 1ns/1ps

// Results of one timing direction, horizontal or vertical
interface timing_if;
    import crtc_pkg::*;

    logic       active;     // Inside the displayed area
    logic       sync;       // Sync pulse level
    char_cnt_t  count;      // Character index or row
    line_cnt_t  sub_count;  // Pixel phase or scanline
    logic       wrap;       // Last unit of the period

    modport gen (
        output active, sync, count, sub_count, wrap
    );

    modport sink (
        input active, sync, count, sub_count, wrap
    );

endinterface

// ==== src/v_timing.sv ====
`timescale 1ns/1ps

module v_timing (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    timing_if.sink                  line_end_i,         // Horizontal results, wrap ends a line
    input  crtc_pkg::line_cnt_t     char_height_i,      // Scanlines per row minus one
    input  crtc_pkg::line_cnt_t     adjust_i,           // Extra lines at frame end
    input  crtc_pkg::char_cnt_t     char_total_i,       // Rows per frame minus one
    input  crtc_pkg::char_cnt_t     char_displayed_i,   // Displayed rows
    input  crtc_pkg::char_cnt_t     sync_start_i,       // First row of vsync
    input  crtc_pkg::sync_width_t   sync_width_i,       // Vsync width in rows
    timing_if.gen                   tim_o
);
    import crtc_pkg::*;

    line_cnt_t    scan;
    line_cnt_t    next_scan;
    char_cnt_t    row;
    char_cnt_t    next_row;
    char_cnt_t    sync_end;
    sync_state_t  state;
    sync_state_t  next_state;
    logic         last_line;        // Last scanline of the frame

    assign next_scan = scan + 1'b1;
    assign next_row  = row + 1'b1;
    assign sync_end  = sync_start_i + char_cnt_t'({sync_width_i == '0, sync_width_i});

    always_comb begin
        if (state == ADJUST) begin
            last_line = next_scan == adjust_i;
        end else begin
            last_line = (scan == char_height_i) && (row == char_total_i) && (adjust_i == '0);
        end
    end

    always_comb begin
        if (next_row == sync_end) begin
            next_state = BACK;
        end else if (next_row == sync_start_i) begin
            next_state = SYNC;
        end else if (next_row == char_displayed_i) begin
            next_state = FRONT;
        end else begin
            next_state = state;
        end
    end

    always_ff @(posedge pixel_clk_i or posedge reset_i) begin
        if (reset_i) begin
            scan  <= '0;
            row   <= '0;
            state <= ACTIVE;
        end else if (line_end_i.wrap) begin
            if (last_line) begin
                scan  <= '0;                // New frame
                row   <= '0;
                state <= ACTIVE;
            end else if (state == ADJUST) begin
                scan <= next_scan;
            end else if (scan == char_height_i) begin
                scan <= '0;
                if (row == char_total_i) begin
                    state <= ADJUST;        // Row stays at R4 through the adjust lines
                end else begin
                    row   <= next_row;
                    state <= next_state;
                end
            end else begin
                scan <= next_scan;
            end
        end
    end

    assign tim_o.active    = state == ACTIVE;
    assign tim_o.sync      = state == SYNC;
    assign tim_o.count     = row;
    assign tim_o.sub_count = scan;
    assign tim_o.wrap      = last_line;     // Level for the whole last line

endmodule

// ==== tb.f ====
src/crtc_pkg.sv
src/timing_if.sv
src/crtc_regs.sv
src/h_timing.sv
src/v_timing.sv
src/dot_gen.sv
src/crtc_video_top.sv
tests/crtc_properties.sv
tests/crtc_tb.sv

// ==== tests/crtc_properties.sv ====
`timescale 1ns/1ps

module crtc_properties (
    input  logic                    pixel_clk_i,
    input  logic                    reset_i,
    input  crtc_pkg::pixel_phase_t  phase_i,
    input  crtc_pkg::bus_addr_t     bus_addr_i,
    input  logic                    gate_i,
    input  logic                    video_i
);
    import crtc_pkg::*;

    // Character ROM is addressed only in its two fetch cycles
    rom_window_only: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        bus_addr_i[11] |-> (phase_i == 3'd2 || phase_i == 3'd3))
        else $error("ROM address outside phases 2 and 3");

    blank_when_gated: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        !gate_i |-> !video_i)
        else $error("video high while the active gate is low");

    phase_wraps: assert property (@(posedge pixel_clk_i) disable iff (reset_i)
        phase_i == 3'd7 |=> phase_i == 3'd0)
        else $error("pixel phase did not wrap from 7 to 0");

endmodule

bind dot_gen crtc_properties dot_props (
    .pixel_clk_i (pixel_clk_i),
    .reset_i     (reset_i),
    .phase_i     (phase),
    .bus_addr_i  (bus_addr_o),
    .gate_i      (gate),
    .video_i     (video_o)
);

bind h_timing crtc_properties h_props (
    .pixel_clk_i (pixel_clk_i),
    .reset_i     (reset_i),
    .phase_i     (phase),
    .bus_addr_i  (12'h000),        // No bus here, only the phase check applies
    .gate_i      (1'b1),
    .video_i     (1'b0)
);

// ==== tests/crtc_stim.txt ====
// R0 R1 R2 R3 R4 R5 R6 R7 R8 R9 R12 R13, then line clocks, hsync clocks,
// frame lines and vsync lines, all in hex
3F 28 30 15 20 00 19 1C 00 07 00 00 200 28 108 08
2F 1E 20 20 0A 03 06 07 00 05 00 10 180 80 45 0C
1F 18 1A 13 07 00 05 06 00 03 07 F0 100 18 20 04
27 14 1C 44 0F 05 08 0A 00 09 01 23 140 20 A5 28

// ==== tests/crtc_tb.sv ====
`timescale 1ns/1ps

module crtc_tb;
    import crtc_pkg::*;

    localparam int NUM_MODES = 4;
    localparam int FIELDS    = 16;
    localparam int F_R12     = 10;      // Field positions inside one stim line
    localparam int F_R13     = 11;
    localparam int F_LINE    = 12;
    localparam int F_HSW     = 13;
    localparam int F_FRAME   = 14;
    localparam int F_VSW     = 15;

    logic        clk;
    logic        rst;
    logic        reg_we;
    logic [3:0]  reg_addr;
    byte_t       reg_wdata;
    bus_addr_t   bus_addr;
    byte_t       bus_data;
    logic        video;
    logic        h_sync;
    logic        v_sync;

    logic [15:0] stim [NUM_MODES * FIELDS];
    byte_t       mem [4096];
    int          m [FIELDS];            // Values of the mode under test
    int          error_count = 0;
    int          limit_cycles = 0;

    logic        run_en;
    logic        synced;
    logic        video_on;
    logic        have_hrise;
    logic        prev_h;
    logic        prev_v;
    byte_t       cur_byte;              // Expected pixels of the character being shifted
    int          hpos;
    int          line;
    int          cycle;
    int          last_hrise;
    int          hs_len;
    int          frame_hr;
    int          vs_hr;
    int          frames_done;

    crtc_video_top uut (
        .pixel_clk_i (clk),
        .reset_i     (rst),
        .reg_we_i    (reg_we),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .bus_addr_o  (bus_addr),
        .bus_data_i  (bus_data),
        .video_o     (video),
        .h_sync_o    (h_sync),
        .v_sync_o    (v_sync)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Memory answers one cycle after the address
    always @(posedge clk) bus_data <= mem[bus_addr];

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic fill_memory();
        logic [31:0] s;
        s = 32'h7952f9f7;
        for (int a = 0; a < 4096; a++) begin
            for (int b = 0; b < 8; b++) begin
                s = lfsr_next(s);
                mem[a][b] = s[0];
            end
        end
    endtask

    task automatic check_value(input int got, input int exp, input string what);
        if (got != exp) begin
            error_count++;
            $display("error at %0t: %s, got %0d expected %0d", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    // RAM address of character c on frame line ln
    function automatic int ram_address(input int c, input int ln);
        int row;
        row = ln / (m[9] + 1);
        return (((m[F_R12] & 7) << 8) + m[F_R13] + row * m[1] + c) & 'h7FF;
    endfunction

    // ROM address of the glyph row for character c on frame line ln
    function automatic int rom_address(input int c, input int ln);
        byte_t code;
        code = mem[ram_address(c, ln)];
        return 'h800 + int'(code[6:0]) * 8 + (ln % (m[9] + 1)) % 8;
    endfunction

    // Pixels of character c on frame line ln, reverse applied, zero when blanked
    function automatic byte_t predict_byte(input int c, input int ln);
        byte_t code;
        byte_t glyph;
        if (c >= m[1] || ln / (m[9] + 1) >= m[6]) begin
            return 8'h00;
        end
        code  = mem[ram_address(c, ln)];
        glyph = mem[rom_address(c, ln)];
        return code[7] ? ~glyph : glyph;
    endfunction

    always @(negedge clk) begin : monitor
        logic h_rise;
        logic v_rise;
        int   phase;
        if (run_en) begin
            h_rise = h_sync && !prev_h;
            v_rise = v_sync && !prev_v;
            if (h_rise) hpos = m[2] * 8;                // Hsync rises at phase 0 of char R2
            if (v_rise) line = m[7] * (m[9] + 1);
            phase = hpos % 8;
            if (h_rise && synced) begin
                if (have_hrise) check_value(cycle - last_hrise, m[F_LINE], "line length");
                have_hrise = 1'b1;
                last_hrise = cycle;
                frame_hr++;
                if (v_sync) vs_hr++;
            end
            if (h_sync) begin
                hs_len++;
            end else begin
                if (prev_h && have_hrise) check_value(hs_len, m[F_HSW], "hsync width");
                hs_len = 0;
            end
            if (v_rise) begin
                if (synced) begin
                    check_value(frame_hr, m[F_FRAME], "frame length in lines");
                    check_value(vs_hr, m[F_VSW], "vsync width in lines");
                    frames_done++;
                end
                synced   = 1'b1;
                frame_hr = 0;
                vs_hr    = 0;
            end
            if (synced && !video_on && line == 0 && hpos == 0) begin
                video_on = 1'b1;                        // Last char before is always blanked
                cur_byte = 8'h00;
            end
            if (video_on) begin
                check_value(video, cur_byte[7 - phase], "video pixel");
                if (hpos / 8 < m[1] && line / (m[9] + 1) < m[6]) begin
                    if (phase == 0) begin
                        check_value(bus_addr, ram_address(hpos / 8, line), "RAM bus address");
                    end
                    if (phase == 2) begin
                        check_value(bus_addr, rom_address(hpos / 8, line), "ROM bus address");
                    end
                end
                if (phase == 7) cur_byte = predict_byte(hpos / 8, line);
            end
            hpos++;
            if (hpos == m[F_LINE]) begin
                hpos = 0;
                line++;
                if (line == m[F_FRAME]) line = 0;
            end
            cycle++;
            prev_h = h_sync;
            prev_v = v_sync;
        end
    end

    task automatic check_startup();
        repeat (8) begin
            @(negedge clk);
            check_value(video, 0, "video after reset");
            check_value(h_sync, 0, "hsync after reset");
            check_value(v_sync, 0, "vsync after reset");
        end
        @(posedge clk);
    endtask

    task automatic write_mode();
        for (int r = 0; r < 12; r++) begin
            @(posedge clk);
            reg_we    <= 1'b1;
            reg_addr  <= (r < 10) ? 4'(r) : 4'(r + 2);   // R0 to R9, then R12 and R13
            reg_wdata <= 8'(m[r]);
        end
        @(posedge clk);
        reg_we <= 1'b0;
    endtask

    task automatic run_mode(input int k);
        for (int f = 0; f < FIELDS; f++) begin
            m[f] = int'(stim[k * FIELDS + f]);
        end
        run_en      = 1'b0;
        synced      = 1'b0;
        video_on    = 1'b0;
        have_hrise  = 1'b0;
        prev_h      = 1'b0;
        prev_v      = 1'b0;
        cur_byte    = 8'h00;
        hpos        = 0;
        line        = 0;
        cycle       = 0;
        hs_len      = 0;
        frame_hr    = 0;
        vs_hr       = 0;
        frames_done = 0;
        @(posedge clk);
        rst <= 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        if (k == 0) begin
            check_startup();                            // Default mode, no writes
        end else begin
            write_mode();
        end
        run_en = 1'b1;
        while (frames_done < 2) @(negedge clk);
        run_en = 1'b0;
    endtask

    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired, run did not finish within %0d clocks", limit_cycles);
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

    initial begin
        int total;
        rst       = 1'b1;
        reg_we    = 1'b0;
        reg_addr  = 4'h0;
        reg_wdata = 8'h00;
        bus_data  = 8'h00;
        run_en    = 1'b0;
        for (int i = 0; i < NUM_MODES * FIELDS; i++) begin
            stim[i] = 16'h0000;
        end
        $readmemh("tests/crtc_stim.txt", stim);
        if (stim[F_LINE] == 16'h0000) begin
            $display("stim file tests/crtc_stim.txt could not be read");
            $display("RESULT: FAIL");
            $fatal(1, "no stimulus");
        end
        fill_memory();
        // Each mode needs up to three frames plus reset and writes
        total = 0;
        for (int k = 0; k < NUM_MODES; k++) begin
            total += 2 * (3 * int'(stim[k * FIELDS + F_FRAME])
                * int'(stim[k * FIELDS + F_LINE]) + 64);
        end
        limit_cycles = total;
        for (int k = 0; k < NUM_MODES; k++) begin
            run_mode(k);
        end
        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

endmodule
